//--- sources.f
rtl/cart_pkg.sv
rtl/rom_header_detect.sv
rtl/cheat_code_loader.sv
rtl/wram_clear.sv
rtl/backup_sequencer.sv
rtl/cart_loader.sv
tb/cart_loader_sva.sv
tb/tb_cart_loader.sv

//--- Bender.yml
package:
  name: cart_loader

sources:
  - rtl/cart_pkg.sv
  - rtl/rom_header_detect.sv
  - rtl/cheat_code_loader.sv
  - rtl/wram_clear.sv
  - rtl/backup_sequencer.sv
  - rtl/cart_loader.sv
  - target: test
    files:
      - tb/cart_loader_sva.sv
      - tb/tb_cart_loader.sv

//--- tb/tb_cart_loader.sv
//====================================================================
// Directed testbench for the cartridge download logic. Drives host
// download streams, models the SD card acknowledge and checks header
// detection, cheat codes, work-RAM clear and backup transfers.
//====================================================================

module tb_cart_loader;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD      = 20;
	localparam int SWEEP_LEN       = 1 << cart_pkg::WRAM_ADDR_W;
	localparam int N_TESTS         = 6;
	localparam int WATCHDOG_CYCLES = N_TESTS * (2 * SWEEP_LEN + 2000);
	localparam logic [7:0] IDX_CODE = 8'hFF;

	logic                              clk_sys;
	logic                              reset;
	logic                              ioctl_download;
	logic [7:0]                        ioctl_index;
	logic [cart_pkg::IO_ADDR_W-1:0]    ioctl_addr;
	logic [cart_pkg::IO_DATA_W-1:0]    ioctl_dout;
	logic                              ioctl_wr;
	cart_pkg::header_mode_e            header_mode;
	cart_pkg::fill_mode_e              fill_mode;
	logic                              img_mounted;
	logic                              img_readonly;
	logic [63:0]                       img_size;
	logic                              bk_load_req;
	logic                              bk_save_req;
	logic                              sd_ack;
	logic [7:0]                        rom_type;
	logic                              rom_region;
	logic [cart_pkg::MASK_W-1:0]       rom_mask;
	logic [cart_pkg::MASK_W-1:0]       ram_mask;
	logic [cart_pkg::GG_CODE_W-1:0]    gg_code;
	logic                              gg_valid;
	logic [cart_pkg::WRAM_ADDR_W-1:0]  fill_addr;
	logic [7:0]                        fill_data;
	logic                              fill_we;
	logic                              clearing;
	logic [cart_pkg::LBA_W-1:0]        sd_lba;
	logic                              sd_rd;
	logic                              sd_wr;
	logic                              bk_busy;
	logic                              bk_loading;
	logic                              bk_enabled;

	int                                sd_ack_delay;
	int                                errors;
	int                                checks;
	int                                gg_pulses;
	logic [31:0]                       lfsr_state;
	logic [cart_pkg::LBA_W-1:0]        sector_lba[$];
	logic                              sector_write[$];

	cart_loader cart_loader_inst (.*);

	bind cart_loader cart_loader_sva cart_loader_sva_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sd_rd     (sd_rd),
		.sd_wr     (sd_wr),
		.gg_valid  (gg_valid),
		.fill_we   (fill_we),
		.fill_addr (fill_addr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	//====================================================================
	// SD card model that logs every sector it serves
	//====================================================================

	initial begin
		forever begin
			@(posedge clk_sys);
			if (!reset && (sd_rd || sd_wr)) begin
				sector_lba.push_back(sd_lba);
				sector_write.push_back(sd_wr);
				repeat (sd_ack_delay) @(posedge clk_sys);
				sd_ack <= 1'b1;
				repeat (4) @(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (gg_valid) begin
			gg_pulses++;
		end
	end

	//====================================================================
	// Helpers
	//====================================================================

	task automatic check(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("ERROR: %s", what);
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic random_word(output logic [15:0] word);
		int i;
		word = '0;
		for (i = 0; i < 16; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			word = {word[14:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [7:0] expected_fill(input cart_pkg::fill_mode_e mode,
		input logic [16:0] addr);
		case (mode)
			cart_pkg::FILL_9966: return (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::FILL_00FF: return (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::FILL_55:   return 8'h55;
			default:             return 8'hFF;
		endcase
	endfunction

	task automatic begin_download(input logic [7:0] index);
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (bk_busy !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy !== level) begin
			report_failure(what);
		end
	endtask

	task automatic wait_clear_idle();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (clearing && n < 2 * SWEEP_LEN) begin
			@(negedge clk_sys);
			n++;
		end
		if (clearing) begin
			report_failure("work-RAM clear never went idle");
		end
	endtask

	task automatic verify_sectors(input int count, input logic is_write);
		int i;
		check("sector count", sector_lba.size(), count);
		for (i = 0; i < sector_lba.size() && i < count; i++) begin
			check("sd_lba", sector_lba[i], i);
			check("sd_wr", sector_write[i], is_write);
		end
	endtask

	//====================================================================
	// Directed tests
	//====================================================================

	task automatic reset_defaults();
		@(negedge clk_sys);
		check("fill_we", fill_we, 1'b0);
		check("clearing", clearing, 1'b0);
		check("gg_valid", gg_valid, 1'b0);
		check("sd_rd", sd_rd, 1'b0);
		check("sd_wr", sd_wr, 1'b0);
		check("bk_busy", bk_busy, 1'b0);
		check("bk_loading", bk_loading, 1'b0);
		check("bk_enabled", bk_enabled, 1'b0);
	endtask

	task automatic auto_header();
		@(posedge clk_sys);
		header_mode <= cart_pkg::HDR_AUTO;
		begin_download(8'h00);
		write_word(25'h0, 16'h0123);
		write_word(25'h2, 16'h0100);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check("rom_type", rom_type, 8'h01);
		check("ram_mask", ram_mask, 24'h000FFF);
		check("rom_mask", rom_mask, 24'h001FFF);
		check("rom_region", rom_region, 1'b1);
		end_download();
	endtask

	task automatic layout_headers();
		@(posedge clk_sys);
		header_mode <= cart_pkg::HDR_HIROM;
		begin_download(8'h00);
		write_word(25'h0, 16'h0000);
		write_word(25'h0101D6, 16'h0A00);
		write_word(25'h0101D8, 16'h0003);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check("rom_type", rom_type, 8'h01);
		check("rom_mask", rom_mask, 24'h0FFFFF);
		check("ram_mask", ram_mask, 24'h001FFF);
		end_download();

		// LoROM with no backup RAM
		@(posedge clk_sys);
		header_mode <= cart_pkg::HDR_LOROM;
		begin_download(8'h00);
		write_word(25'h0, 16'h0000);
		write_word(25'h0081D6, 16'h0B00);
		write_word(25'h0081D8, 16'h0000);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check("rom_type", rom_type, 8'h00);
		check("rom_mask", rom_mask, 24'h1FFFFF);
		check("ram_mask", ram_mask, 24'h000000);
		end_download();
	endtask

	task automatic cheat_code();
		logic [15:0] words [8];
		int i;
		gg_pulses = 0;
		for (i = 0; i < 8; i++) begin
			random_word(words[i]);
		end
		begin_download(IDX_CODE);
		for (i = 0; i < 7; i++) begin
			write_word(25'(i * 2), words[i]);
		end
		@(negedge clk_sys);
		check("gg_valid", gg_valid, 1'b0);
		write_word(25'd14, words[7]);
		@(negedge clk_sys);
		check("gg_valid", gg_valid, 1'b1);
		@(negedge clk_sys);
		check("gg_valid", gg_valid, 1'b0);
		end_download();
		check("gg_valid pulses", gg_pulses, 1);
		check("gg_code flags", gg_code[127:96], {words[1], words[0]});
		check("gg_code address", gg_code[95:64], {words[3], words[2]});
		check("gg_code compare", gg_code[63:32], {words[5], words[4]});
		check("gg_code replace", gg_code[31:0], {words[7], words[6]});
	endtask

	task automatic wram_clear_sweeps();
		cart_pkg::fill_mode_e mode;
		int m;
		int n;
		int we_cycles;
		for (m = 0; m < 4; m++) begin
			mode = cart_pkg::fill_mode_e'(m);
			wait_clear_idle();
			@(posedge clk_sys);
			fill_mode <= mode;
			begin_download(8'h00);
			n = 0;
			@(negedge clk_sys);
			while (!fill_we && n < 10) begin
				@(negedge clk_sys);
				n++;
			end
			if (!fill_we) begin
				report_failure("work-RAM clear did not start on a cartridge load");
			end else begin
				we_cycles = 0;
				while (fill_we && we_cycles < SWEEP_LEN + 8) begin
					if (we_cycles % 16 == 0 || we_cycles % 16 == 5) begin
						check("clearing", clearing, 1'b1);
						check("fill_addr", fill_addr, we_cycles);
						check("fill_data", fill_data, expected_fill(mode, 17'(we_cycles)));
					end
					we_cycles++;
					@(negedge clk_sys);
				end
				check("fill_we cycles", we_cycles, SWEEP_LEN);
				check("clearing", clearing, 1'b0);
				check("fill_addr", fill_addr, 0);
			end
			end_download();
		end
	endtask

	task automatic auto_backup_load();
		@(posedge clk_sys);
		header_mode  <= cart_pkg::HDR_AUTO;
		img_mounted  <= 1'b1;
		img_readonly <= 1'b0;
		img_size     <= 64'h2000;
		begin_download(8'h00);
		// RAM size 3, ROM size 8
		write_word(25'h0, 16'h0038);
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("ram_mask", ram_mask, 24'h001FFF);
		check("bk_enabled", bk_enabled, 1'b1);
		sector_lba.delete();
		sector_write.delete();
		end_download();
		wait_busy(1'b1, 20, "automatic load did not start after the download");
		check("bk_loading", bk_loading, 1'b1);
		wait_busy(1'b0, 2000, "automatic load did not finish");
		check("bk_loading", bk_loading, 1'b0);
		verify_sectors(16, 1'b0);
	endtask

	task automatic save_and_readonly();
		int n;
		logic started;
		sector_lba.delete();
		sector_write.delete();
		@(posedge clk_sys);
		bk_save_req <= 1'b1;
		wait_busy(1'b1, 20, "save request did not start a transfer");
		check("bk_loading", bk_loading, 1'b0);
		@(posedge clk_sys);
		bk_save_req <= 1'b0;
		wait_busy(1'b0, 2000, "save transfer did not finish");
		verify_sectors(16, 1'b1);

		@(posedge clk_sys);
		img_readonly <= 1'b1;
		begin_download(8'h00);
		write_word(25'h0, 16'h0038);
		repeat (4) @(posedge clk_sys);
		end_download();
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("bk_enabled", bk_enabled, 1'b0);
		sector_lba.delete();
		sector_write.delete();
		@(posedge clk_sys);
		bk_save_req <= 1'b1;
		started = 1'b0;
		for (n = 0; n < 50; n++) begin
			@(negedge clk_sys);
			if (bk_busy) begin
				started = 1'b1;
			end
		end
		@(posedge clk_sys);
		bk_save_req <= 1'b0;
		if (started) begin
			report_failure("save request started a transfer with a read-only image");
		end
		check("sector count", sector_lba.size(), 0);
	endtask

	//====================================================================
	// Main sequence
	//====================================================================

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		header_mode    = cart_pkg::HDR_AUTO;
		fill_mode      = cart_pkg::FILL_9966;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		sd_ack         = 1'b0;
		sd_ack_delay   = 3;
		errors         = 0;
		checks         = 0;
		gg_pulses      = 0;
		lfsr_state     = 32'h451d;

		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;

		reset_defaults();
		auto_header();
		layout_headers();
		cheat_code();
		wram_clear_sweeps();
		auto_backup_load();
		save_and_readonly();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- tb/cart_loader_sva.sv
//====================================================================
// Protocol assertions for the cartridge download logic. Bound into
// the top level, where the SD requests, the cheat valid flag and the
// work-RAM clear outputs all meet.
//====================================================================

module cart_loader_sva (
	input logic                              clk_sys,
	input logic                              reset,
	input logic                              sd_rd,
	input logic                              sd_wr,
	input logic                              gg_valid,
	input logic                              fill_we,
	input logic [cart_pkg::WRAM_ADDR_W-1:0]  fill_addr
);

	timeunit 1ns;
	timeprecision 1ps;

	// One sector direction at a time
	sd_req_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr are high together");

	gg_valid_single: assert property (@(posedge clk_sys) disable iff (reset)
		gg_valid |=> !gg_valid)
		else $error("gg_valid stayed high for two cycles");

	// Sweep steps one address per write cycle
	fill_addr_step: assert property (@(posedge clk_sys) disable iff (reset)
		fill_we ##1 fill_we |-> fill_addr == $past(fill_addr) + 1'b1)
		else $error("fill_addr did not advance by one during the clear");

endmodule

//--- rtl/cart_loader.sv
//====================================================================
// Cartridge download control, top level. Decodes the host download
// index into cartridge and cheat-code streams and ties together
// header detection, cheat assembly, work-RAM clear and backup-RAM
// transfer.
//====================================================================

module cart_loader (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              ioctl_download,
	input  logic [7:0]                        ioctl_index,
	input  logic [cart_pkg::IO_ADDR_W-1:0]    ioctl_addr,
	input  logic [cart_pkg::IO_DATA_W-1:0]    ioctl_dout,
	input  logic                              ioctl_wr,
	input  cart_pkg::header_mode_e            header_mode,
	input  cart_pkg::fill_mode_e              fill_mode,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic [63:0]                       img_size,
	input  logic                              bk_load_req,
	input  logic                              bk_save_req,
	input  logic                              sd_ack,
	output logic [7:0]                        rom_type,
	output logic                              rom_region,
	output logic [cart_pkg::MASK_W-1:0]       rom_mask,
	output logic [cart_pkg::MASK_W-1:0]       ram_mask,
	output logic [cart_pkg::GG_CODE_W-1:0]    gg_code,
	output logic                              gg_valid,
	output logic [cart_pkg::WRAM_ADDR_W-1:0]  fill_addr,
	output logic [7:0]                        fill_data,
	output logic                              fill_we,
	output logic                              clearing,
	output logic [cart_pkg::LBA_W-1:0]        sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic                              bk_busy,
	output logic                              bk_loading,
	output logic                              bk_enabled
);

	logic cart_download;
	logic code_download;
	logic load_start;

	// Index decode, cheats use the all-ones index
	assign cart_download = ioctl_download && ioctl_index[5:0] == cart_pkg::IDX_CART;
	assign code_download = ioctl_download && (&ioctl_index);

	rom_header_detect rom_header_detect_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.ioctl_wr      (ioctl_wr),
		.header_mode   (header_mode),
		.rom_type      (rom_type),
		.rom_region    (rom_region),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask)
	);

	cheat_code_loader cheat_code_loader_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.ioctl_addr    (ioctl_addr[3:0]),
		.ioctl_dout    (ioctl_dout),
		.ioctl_wr      (ioctl_wr),
		.gg_code       (gg_code),
		.gg_valid      (gg_valid)
	);

	wram_clear wram_clear_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_start (load_start),
		.fill_mode  (fill_mode),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data),
		.fill_we    (fill_we),
		.clearing   (clearing)
	);

	backup_sequencer backup_sequencer_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ram_mask      (ram_mask),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.sd_ack        (sd_ack),
		.load_start    (load_start),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_enabled    (bk_enabled)
	);

endmodule

//--- rtl/backup_sequencer.sv
//====================================================================
// Backup-RAM transfer sequencer. Tracks the cartridge download edges,
// enables backup RAM for a writable save image, and moves backup RAM
// to or from the SD card one 512-byte sector at a time, on request
// or automatically at the end of a cartridge load.
//====================================================================

module backup_sequencer (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          cart_download,
	input  logic [cart_pkg::MASK_W-1:0]   ram_mask,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic [63:0]                   img_size,
	input  logic                          bk_load_req,
	input  logic                          bk_save_req,
	input  logic                          sd_ack,
	output logic                          load_start,
	output logic [cart_pkg::LBA_W-1:0]    sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output logic                          bk_busy,
	output logic                          bk_loading,
	output logic                          bk_enabled
);

	cart_pkg::bk_state_e              state;
	logic                             cart_dl_q;
	logic                             load_req_q;
	logic                             save_req_q;
	logic                             ack_q;
	logic                             auto_load;
	logic                             load_rise;
	logic                             save_rise;
	logic                             start_load;
	logic                             start_xfer;
	logic                             ack_rise;
	logic                             ack_fall;
	logic [cart_pkg::LBA_W-1:0]       lba_last;

	//====================================================================
	// Edge detection
	//====================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q  <= 1'b0;
			load_req_q <= 1'b0;
			save_req_q <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			cart_dl_q  <= cart_download;
			load_req_q <= bk_load_req;
			save_req_q <= bk_save_req;
			ack_q      <= sd_ack;
		end
	end

	assign load_start = cart_download & ~cart_dl_q;
	assign auto_load  = cart_dl_q & ~cart_download & (|img_size) & bk_enabled;
	assign load_rise  = bk_load_req & ~load_req_q & bk_enabled;
	assign save_rise  = bk_save_req & ~save_req_q & bk_enabled;
	assign start_load = auto_load | load_rise;
	assign start_xfer = start_load | save_rise;
	assign ack_rise   = sd_ack & ~ack_q;
	assign ack_fall   = ack_q & ~sd_ack;

	// One sector per 512 bytes of backup RAM
	assign lba_last = {{(cart_pkg::LBA_W - cart_pkg::MASK_W + 9){1'b0}},
		ram_mask[cart_pkg::MASK_W-1:9]};

	// Save image is mounted by the time the download runs
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_enabled <= 1'b0;
		end else if (load_start) begin
			bk_enabled <= 1'b0;
		end else if (cart_download && img_mounted && !img_readonly) begin
			bk_enabled <= |ram_mask;
		end
	end

	//====================================================================
	// Transfer FSM
	//====================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= cart_pkg::BK_IDLE;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			// Request drops once the SD side takes it
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				cart_pkg::BK_IDLE: begin
					if (start_xfer) begin
						state      <= cart_pkg::BK_XFER;
						bk_loading <= start_load;
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
					end
				end
				cart_pkg::BK_XFER: begin
					if (ack_fall) begin
						if (sd_lba >= lba_last) begin
							state      <= cart_pkg::BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
			endcase
		end
	end

	assign bk_busy = (state == cart_pkg::BK_XFER);

endmodule

//--- rtl/wram_clear.sv
//====================================================================
// Work-RAM clear. A load_start pulse starts one sweep over the whole
// 128 KB work RAM, one address per cycle, writing the selected
// power-on pattern. fill_data is decoded straight from fill_addr.
//====================================================================

module wram_clear (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              load_start,
	input  cart_pkg::fill_mode_e              fill_mode,
	output logic [cart_pkg::WRAM_ADDR_W-1:0]  fill_addr,
	output logic [7:0]                        fill_data,
	output logic                              fill_we,
	output logic                              clearing
);

	logic sweep_last;

	assign sweep_last = &fill_addr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (clearing && sweep_last) begin
				clearing <= 1'b0;
			end else if (load_start) begin
				clearing <= 1'b1;
			end

			// Address parks at zero between sweeps
			if (clearing) begin
				fill_addr <= fill_addr + 1'b1;
			end else begin
				fill_addr <= '0;
			end
		end
	end

	assign fill_we = clearing;

	// Pattern per console revision / flash cart
	always_comb begin
		case (fill_mode)
			cart_pkg::FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::FILL_55:   fill_data = 8'h55;
			default:             fill_data = 8'hFF;
		endcase
	end

endmodule

//--- rtl/cheat_code_loader.sv
//====================================================================
// Cheat code assembly. Eight 16-bit words of a code download build
// one 128-bit code: flags, address, compare and replace values.
// gg_valid pulses for one cycle once the last word is stored.
//====================================================================

module cheat_code_loader (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            code_download,
	input  logic [3:0]                      ioctl_addr,
	input  logic [cart_pkg::IO_DATA_W-1:0]  ioctl_dout,
	input  logic                            ioctl_wr,
	output logic [cart_pkg::GG_CODE_W-1:0]  gg_code,
	output logic                            gg_valid
);

	logic code_we;

	assign code_we = code_download & ioctl_wr;

	// Field words, stored the cycle after their write
	always_ff @(posedge clk_sys) begin
		if (code_we) begin
			case (ioctl_addr)
				4'd0:  gg_code[111:96]  <= ioctl_dout;
				4'd2:  gg_code[127:112] <= ioctl_dout;
				4'd4:  gg_code[79:64]   <= ioctl_dout;
				4'd6:  gg_code[95:80]   <= ioctl_dout;
				4'd8:  gg_code[47:32]   <= ioctl_dout;
				4'd10: gg_code[63:48]   <= ioctl_dout;
				4'd12: gg_code[15:0]    <= ioctl_dout;
				4'd14: gg_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Top replace word completes the code
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_valid <= 1'b0;
		end else begin
			gg_valid <= code_we && ioctl_addr == 4'd14;
		end
	end

endmodule

//--- rtl/rom_header_detect.sv
//====================================================================
// ROM header detection. Watches cartridge download writes and picks
// out ROM type, region and the ROM and backup-RAM sizes, either from
// the loader's info word or from the internal header of the chosen
// layout. Masks follow the sizes one cycle later.
//====================================================================

module rom_header_detect (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            cart_download,
	input  logic [cart_pkg::IO_ADDR_W-1:0]  ioctl_addr,
	input  logic [cart_pkg::IO_DATA_W-1:0]  ioctl_dout,
	input  logic                            ioctl_wr,
	input  cart_pkg::header_mode_e          header_mode,
	output logic [7:0]                      rom_type,
	output logic                            rom_region,
	output logic [cart_pkg::MASK_W-1:0]     rom_mask,
	output logic [cart_pkg::MASK_W-1:0]     ram_mask
);

	logic                           hdr_we;
	logic                           layout_en;
	logic [cart_pkg::IO_ADDR_W-1:0] size_addr;
	logic [cart_pkg::SIZE_W-1:0]    rom_size;
	logic [cart_pkg::SIZE_W-1:0]    ram_size;

	assign hdr_we = cart_download & ioctl_wr;

	// Address of the ROM-size byte for the forced layouts
	always_comb begin
		layout_en = 1'b1;
		size_addr = cart_pkg::HDR_LO + cart_pkg::HDR_BASE;
		case (header_mode)
			cart_pkg::HDR_LOROM:   size_addr = cart_pkg::HDR_LO + cart_pkg::HDR_BASE;
			cart_pkg::HDR_HIROM:   size_addr = cart_pkg::HDR_HI + cart_pkg::HDR_BASE;
			cart_pkg::HDR_EXHIROM: size_addr = cart_pkg::HDR_EXHI + cart_pkg::HDR_BASE;
			default:               layout_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size   <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size   <= '0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
		end else if (hdr_we) begin
			if (ioctl_addr == cart_pkg::HDR_INFO_ADDR) begin
				rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
				ram_size <= '0;
				// Loader info byte: RAM size high nibble, ROM size low
				if (header_mode == cart_pkg::HDR_AUTO && ioctl_dout[7:0] != 8'h00) begin
					{ram_size, rom_size} <= ioctl_dout[7:0];
				end
				case (header_mode)
					cart_pkg::HDR_AUTO:    rom_type <= ioctl_dout[15:8];
					cart_pkg::HDR_HIROM:   rom_type <= 8'd1;
					cart_pkg::HDR_EXHIROM: rom_type <= 8'd2;
					default:               rom_type <= 8'd0;
				endcase
			end

			if (ioctl_addr == cart_pkg::HDR_REGION_ADDR) begin
				rom_region <= ioctl_dout[8];
			end

			if (layout_en) begin
				if (ioctl_addr == size_addr) begin
					rom_size <= ioctl_dout[11:8];
				end
				if (ioctl_addr == size_addr + cart_pkg::HDR_RAM_OFS) begin
					ram_size <= ioctl_dout[3:0];
				end
			end
		end
	end

	// Masks trail the size registers by one cycle
	always_ff @(posedge clk_sys) begin
		rom_mask <= (cart_pkg::SIZE_UNIT << rom_size) - 1'b1;
		if (ram_size != '0) begin
			ram_mask <= (cart_pkg::SIZE_UNIT << ram_size) - 1'b1;
		end else begin
			ram_mask <= '0;
		end
	end

endmodule

//--- rtl/cart_pkg.sv
//====================================================================
// Shared widths, download constants and enums for the cartridge
// download logic. All blocks refer to these through cart_pkg:: names.
//====================================================================

package cart_pkg;

	// Widths
	localparam int IO_ADDR_W   = 25;
	localparam int IO_DATA_W   = 16;
	localparam int MASK_W      = 24;
	localparam int WRAM_ADDR_W = 17;
	localparam int LBA_W       = 32;
	localparam int GG_CODE_W   = 128;
	localparam int SIZE_W      = 4;

	// Cartridge index, compared on the low six bits only
	localparam logic [5:0] IDX_CART = 6'd0;

	//====================================================================
	// Header locations
	//====================================================================

	// Copier header in front of the image
	localparam logic [IO_ADDR_W-1:0] HDR_BASE = 25'h000200;

	// Words written by the host loader at the start of the stream
	localparam logic [IO_ADDR_W-1:0] HDR_INFO_ADDR   = 25'h000000;
	localparam logic [IO_ADDR_W-1:0] HDR_REGION_ADDR = 25'h000002;

	// ROM-size byte per layout, RAM-size word sits 2 above
	localparam logic [IO_ADDR_W-1:0] HDR_LO      = 25'h007FD6;
	localparam logic [IO_ADDR_W-1:0] HDR_HI      = 25'h00FFD6;
	localparam logic [IO_ADDR_W-1:0] HDR_EXHI    = 25'h40FFD6;
	localparam logic [IO_ADDR_W-1:0] HDR_RAM_OFS = 25'h000002;

	localparam logic [SIZE_W-1:0] DEFAULT_ROM_SIZE = 4'hC;

	// Masks are (unit << size) - 1
	localparam logic [MASK_W-1:0] SIZE_UNIT = 24'd1024;

	//====================================================================
	// Enums
	//====================================================================

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_mode_e;

	typedef enum logic [0:0] {
		BK_IDLE = 1'b0,
		BK_XFER = 1'b1
	} bk_state_e;

endpackage
